//--- maze_game.f
verilog/game_pkg.sv
verilog/heading_stage.sv
verilog/player_mover.sv
verilog/food_eater.sv
verilog/ghost_check.sv
verilog/tile_painter.sv
verilog/maze_game.sv
test/maze_game_chk.sv
test/maze_game_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the maze_game testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module maze_game_tb \
    -f maze_game.f \
    -o maze_game_sim

./obj_dir/maze_game_sim +verilator+error+limit+100 > sim.log 2>&1 || {
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
}
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

//--- test/maze_game_chk.sv
`timescale 1ns/1ns
`default_nettype none

module maze_game_chk (
    input logic clock,
    input logic resetn,
    input logic step,
    input logic tile_wr,
    input logic game_over
);

    int violations = 0; // Read back by the testbench

    // Every step needs two cycles of tile writes
    step_spacing: assert property (@(posedge clock) disable iff (!resetn) step |=> !step)
        else begin
            $error("step strobe seen on two consecutive cycles");
            violations++;
        end

    write_burst: assert property (@(posedge clock) disable iff (!resetn)
                                  tile_wr ##1 tile_wr |=> !tile_wr)
        else begin
            $error("tile_wr high for more than two cycles");
            violations++;
        end

    over_sticky: assert property (@(posedge clock) (resetn && game_over) |=> game_over)
        else begin
            $error("game_over fell without a reset");
            violations++;
        end

endmodule

bind maze_game maze_game_chk chk0 (
    .clock     (clock),
    .resetn    (resetn),
    .step      (step),
    .tile_wr   (tile_wr),
    .game_over (game_over)
);

`default_nettype wire

//--- test/maze_game_tb.sv
`timescale 1ns/1ns
`default_nettype none

module maze_game_tb;

    localparam int NUM_ROWS = 21;
    localparam int LOG_DEPTH = 64;
    localparam int MAX_CYCLES = NUM_ROWS * 8 + 100;
    localparam game_pkg::tile_x_t START_X = 5'd1;
    localparam game_pkg::tile_y_t START_Y = 4'd1;

    logic                 clock;
    logic                 resetn;
    logic                 step;
    game_pkg::key_code_t  key;
    game_pkg::tile_x_t    ghost_x;
    game_pkg::tile_y_t    ghost_y;
    logic                 tile_wr;
    game_pkg::tile_addr_t tile_addr;
    game_pkg::tile_code_t tile_code;
    game_pkg::score_t     score;
    logic                 game_over;
    game_pkg::tile_x_t    player_x;
    game_pkg::tile_y_t    player_y;

    // Stimulus and expected results, one row per step
    game_pkg::key_code_t row_key   [NUM_ROWS];
    game_pkg::tile_x_t   row_gx    [NUM_ROWS];
    game_pkg::tile_y_t   row_gy    [NUM_ROWS];
    game_pkg::tile_x_t   row_x     [NUM_ROWS];
    game_pkg::tile_y_t   row_y     [NUM_ROWS];
    game_pkg::score_t    row_score [NUM_ROWS];
    logic                row_over  [NUM_ROWS];
    int row_count = 0;

    // Filled by the write monitor
    game_pkg::tile_addr_t wr_addr_log [LOG_DEPTH];
    game_pkg::tile_code_t wr_code_log [LOG_DEPTH];
    int writes_seen = 0;

    int mismatch_count = 0;
    int other_errors = 0;
    int cycle_count = 0;

    maze_game #(
        .start_x (START_X),
        .start_y (START_Y)
    ) dut0 (
        .clock     (clock),
        .resetn    (resetn),
        .step      (step),
        .key       (key),
        .ghost_x   (ghost_x),
        .ghost_y   (ghost_y),
        .tile_wr   (tile_wr),
        .tile_addr (tile_addr),
        .tile_code (tile_code),
        .score     (score),
        .game_over (game_over),
        .player_x  (player_x),
        .player_y  (player_y)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the step table never completed", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clock) begin
        if (resetn && tile_wr) begin
            if (writes_seen < LOG_DEPTH) begin
                wr_addr_log[writes_seen] = tile_addr;
                wr_code_log[writes_seen] = tile_code;
            end
            writes_seen = writes_seen + 1;
        end
    end

    function automatic game_pkg::tile_addr_t grid_address(game_pkg::tile_x_t x,
                                                          game_pkg::tile_y_t y);
        return game_pkg::tile_addr_t'(int'(y) * 32 + int'(x));
    endfunction

    task automatic tile_x_equal(string name, game_pkg::tile_x_t got, game_pkg::tile_x_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic tile_y_equal(string name, game_pkg::tile_y_t got, game_pkg::tile_y_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic score_equal(string name, game_pkg::score_t got, game_pkg::score_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic addr_equal(string name, game_pkg::tile_addr_t got,
                              game_pkg::tile_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic code_equal(string name, game_pkg::tile_code_t got,
                              game_pkg::tile_code_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic flag_equal(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic add_row(game_pkg::key_code_t k, game_pkg::tile_x_t gx, game_pkg::tile_y_t gy,
                           game_pkg::tile_x_t ex, game_pkg::tile_y_t ey,
                           game_pkg::score_t es, logic eo);
        row_key[row_count]   = k;
        row_gx[row_count]    = gx;
        row_gy[row_count]    = gy;
        row_x[row_count]     = ex;
        row_y[row_count]     = ey;
        row_score[row_count] = es;
        row_over[row_count]  = eo;
        row_count++;
    endtask

    // Start (1,1), pillars where column and row are both 2 mod 4
    task automatic load_table();
        add_row(8'h00,            5'd30, 4'd14, 5'd1, 4'd1, 9'd0, 1'b0); // No heading yet
        add_row(game_pkg::KEY_A, 5'd30, 4'd14, 5'd1, 4'd1, 9'd0, 1'b0); // Left border
        add_row(game_pkg::KEY_W, 5'd30, 4'd14, 5'd1, 4'd1, 9'd0, 1'b0); // Top border
        add_row(game_pkg::KEY_D, 5'd30, 4'd14, 5'd2, 4'd1, 9'd1, 1'b0);
        add_row(game_pkg::KEY_S, 5'd30, 4'd14, 5'd2, 4'd1, 9'd1, 1'b0); // Pillar (2,2)
        add_row(8'hFF,            5'd30, 4'd14, 5'd2, 4'd1, 9'd1, 1'b0); // Still heading down
        add_row(game_pkg::KEY_D, 5'd30, 4'd14, 5'd3, 4'd1, 9'd2, 1'b0);
        add_row(game_pkg::KEY_S, 5'd30, 4'd14, 5'd3, 4'd2, 9'd3, 1'b0);
        add_row(game_pkg::KEY_S, 5'd30, 4'd14, 5'd3, 4'd3, 9'd4, 1'b0);
        add_row(game_pkg::KEY_A, 5'd30, 4'd14, 5'd2, 4'd3, 9'd5, 1'b0);
        add_row(game_pkg::KEY_W, 5'd30, 4'd14, 5'd2, 4'd3, 9'd5, 1'b0); // Pillar again
        add_row(game_pkg::KEY_D, 5'd30, 4'd14, 5'd3, 4'd3, 9'd5, 1'b0); // Revisit
        add_row(8'h00,            5'd30, 4'd14, 5'd4, 4'd3, 9'd6, 1'b0); // Repeats right
        add_row(game_pkg::KEY_W, 5'd30, 4'd14, 5'd4, 4'd2, 9'd7, 1'b0);
        add_row(game_pkg::KEY_W, 5'd30, 4'd14, 5'd4, 4'd1, 9'd8, 1'b0);
        add_row(game_pkg::KEY_A, 5'd30, 4'd14, 5'd3, 4'd1, 9'd8, 1'b0);
        add_row(game_pkg::KEY_A, 5'd30, 4'd14, 5'd2, 4'd1, 9'd8, 1'b0);
        add_row(game_pkg::KEY_A, 5'd30, 4'd14, 5'd1, 4'd1, 9'd8, 1'b0); // Start tile, no food
        add_row(game_pkg::KEY_S, 5'd1,  4'd2,  5'd1, 4'd2, 9'd9, 1'b1); // Lands on the ghost
        add_row(game_pkg::KEY_S, 5'd5,  4'd5,  5'd1, 4'd2, 9'd9, 1'b1); // Refused
        add_row(game_pkg::KEY_D, 5'd5,  4'd5,  5'd1, 4'd2, 9'd9, 1'b1);
    endtask

    initial begin
        game_pkg::tile_x_t old_x;
        game_pkg::tile_y_t old_y;
        logic over;
        int base;
        int count;
        int exp_writes;
        int total;
        step    = 1'b0;
        key     = 8'h00;
        ghost_x = 5'd30;
        ghost_y = 4'd14;
        resetn  = 1'b0;
        load_table();
        repeat (16) @(negedge clock);
        resetn = 1'b1;
        @(negedge clock);
        flag_equal("tile_wr", tile_wr, 1'b0);
        flag_equal("game_over", game_over, 1'b0);
        score_equal("score", score, 9'd0);
        tile_x_equal("player_x", player_x, START_X);
        tile_y_equal("player_y", player_y, START_Y);
        old_x = START_X;
        old_y = START_Y;
        over  = 1'b0;
        for (int i = 0; i < row_count; i++) begin
            key     = row_key[i];
            ghost_x = row_gx[i];
            ghost_y = row_gy[i];
            base    = writes_seen;
            step    = 1'b1;
            @(negedge clock);
            step = 1'b0;
            repeat (7) @(negedge clock); // Step has drained by now
            tile_x_equal("player_x", player_x, row_x[i]);
            tile_y_equal("player_y", player_y, row_y[i]);
            score_equal("score", score, row_score[i]);
            flag_equal("game_over", game_over, row_over[i]);
            count      = writes_seen - base;
            exp_writes = over ? 0 : 2;
            if (count != exp_writes) begin
                $display("Step %0d gave %0d tile writes instead of %0d", i, count, exp_writes);
                other_errors++;
            end else if (exp_writes == 2 && base + 1 < LOG_DEPTH) begin
                addr_equal("tile_addr erase", wr_addr_log[base], grid_address(old_x, old_y));
                code_equal("tile_code erase", wr_code_log[base], game_pkg::TILE_EMPTY);
                addr_equal("tile_addr draw", wr_addr_log[base + 1],
                           grid_address(row_x[i], row_y[i]));
                code_equal("tile_code draw", wr_code_log[base + 1], game_pkg::TILE_PLAYER);
            end
            old_x = row_x[i];
            old_y = row_y[i];
            over  = row_over[i];
        end
        total = mismatch_count + other_errors + dut0.chk0.violations;
        $display("Errors: %0d mismatches, %0d write count errors, %0d assertion failures",
                 mismatch_count, other_errors, dut0.chk0.violations);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/food_eater.sv
`timescale 1ns/1ns
`default_nettype none

module food_eater #(
    parameter game_pkg::tile_x_t start_x = 5'd1,
    parameter game_pkg::tile_y_t start_y = 4'd1
) (
    input  logic              clock,
    input  logic              resetn,
    input  logic              pos_valid,
    input  game_pkg::tile_x_t pos_x,
    input  game_pkg::tile_y_t pos_y,
    output logic              eat_valid,
    output game_pkg::tile_x_t eat_x,
    output game_pkg::tile_y_t eat_y,
    output game_pkg::score_t  score
);

    localparam int tiles = game_pkg::GRID_W * game_pkg::GRID_H;

    logic [tiles-1:0] food_map; // One bit per tile
    game_pkg::tile_addr_t addr;

    // Food on every open tile except where the player starts
    function automatic logic [tiles-1:0] food_init();
        logic [tiles-1:0] map;
        game_pkg::tile_x_t cx;
        game_pkg::tile_y_t cy;
        for (int a = 0; a < tiles; a++) begin
            cx = game_pkg::tile_x_t'(a % game_pkg::GRID_W);
            cy = game_pkg::tile_y_t'(a / game_pkg::GRID_W);
            map[a] = !game_pkg::is_wall(cx, cy);
        end
        map[game_pkg::tile_addr_of(start_x, start_y)] = 1'b0;
        return map;
    endfunction

    assign addr = game_pkg::tile_addr_of(pos_x, pos_y);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            eat_valid <= 1'b0;
            score     <= '0;
            food_map  <= food_init();
        end else begin
            eat_valid <= pos_valid;
            if (pos_valid && food_map[addr]) begin
                food_map[addr] <= 1'b0;
                score          <= score + 1'b1;
            end
        end
    end

    // Position rides along one cycle behind
    always_ff @(posedge clock) begin
        if (pos_valid) begin
            eat_x <= pos_x;
            eat_y <= pos_y;
        end
    end

endmodule

`default_nettype wire

//--- verilog/game_pkg.sv
`default_nettype none

package game_pkg;

    // Playfield size in tiles
    localparam int GRID_W = 32;
    localparam int GRID_H = 16;

    typedef logic [4:0] tile_x_t;    // Column 0..31
    typedef logic [3:0] tile_y_t;    // Row 0..15
    typedef logic [8:0] tile_addr_t; // Row * GRID_W + column
    typedef logic [8:0] score_t;
    typedef logic [7:0] key_code_t;  // PS/2 make code

    // PS/2 set 2 make codes for WASD
    localparam key_code_t KEY_W = 8'h1D;
    localparam key_code_t KEY_A = 8'h1C;
    localparam key_code_t KEY_S = 8'h1B;
    localparam key_code_t KEY_D = 8'h23;

    typedef enum logic [2:0] {
        HEAD_NONE,
        HEAD_UP,
        HEAD_LEFT,
        HEAD_DOWN,
        HEAD_RIGHT
    } heading_t;

    // Codes written into the external tile map
    typedef enum logic [1:0] {
        TILE_EMPTY,
        TILE_WALL,
        TILE_FOOD,
        TILE_PLAYER
    } tile_code_t;

    // Border ring plus a pillar wherever column and row are both 2 mod 4
    function automatic logic is_wall(tile_x_t x, tile_y_t y);
        logic border;
        logic pillar;
        border = (x == tile_x_t'(0)) || (x == tile_x_t'(GRID_W - 1)) ||
                 (y == tile_y_t'(0)) || (y == tile_y_t'(GRID_H - 1));
        pillar = (x[1:0] == 2'd2) && (y[1:0] == 2'd2);
        return border || pillar;
    endfunction

    // GRID_W is a power of two, so the address is row and column side by side
    function automatic tile_addr_t tile_addr_of(tile_x_t x, tile_y_t y);
        return {y, x};
    endfunction

endpackage

`default_nettype wire

//--- verilog/ghost_check.sv
`timescale 1ns/1ns
`default_nettype none

module ghost_check (
    input  logic              clock,
    input  logic              resetn,
    input  logic              eat_valid,
    input  game_pkg::tile_x_t eat_x,
    input  game_pkg::tile_y_t eat_y,
    input  game_pkg::tile_x_t ghost_x,
    input  game_pkg::tile_y_t ghost_y,
    output logic              hit_valid,
    output game_pkg::tile_x_t hit_x,
    output game_pkg::tile_y_t hit_y,
    output logic              game_over
);

    logic on_ghost;

    // Ghost tile only matters when a step reaches this stage
    assign on_ghost = (eat_x == ghost_x) && (eat_y == ghost_y);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            hit_valid <= 1'b0;
            game_over <= 1'b0;
        end else begin
            hit_valid <= eat_valid;
            if (eat_valid && on_ghost) begin
                game_over <= 1'b1; // Sticky until reset
            end
        end
    end

    always_ff @(posedge clock) begin
        if (eat_valid) begin
            hit_x <= eat_x;
            hit_y <= eat_y;
        end
    end

endmodule

`default_nettype wire

//--- verilog/heading_stage.sv
`timescale 1ns/1ns
`default_nettype none

module heading_stage (
    input  logic                clock,
    input  logic                resetn,
    input  logic                step,
    input  game_pkg::key_code_t key,
    input  logic                game_over,
    output logic                move_valid,
    output game_pkg::heading_t  heading
);

    logic accept;
    game_pkg::heading_t key_heading;

    assign accept = step && !game_over; // Steps are refused once the game is over

    // Unknown keys keep the heading already held
    always_comb begin
        case (key)
            game_pkg::KEY_W: key_heading = game_pkg::HEAD_UP;
            game_pkg::KEY_A: key_heading = game_pkg::HEAD_LEFT;
            game_pkg::KEY_S: key_heading = game_pkg::HEAD_DOWN;
            game_pkg::KEY_D: key_heading = game_pkg::HEAD_RIGHT;
            default:         key_heading = heading;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            move_valid <= 1'b0;
            heading    <= game_pkg::HEAD_NONE;
        end else begin
            move_valid <= accept;
            if (accept) begin
                heading <= key_heading;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/maze_game.sv
`timescale 1ns/1ns
`default_nettype none

module maze_game #(
    parameter game_pkg::tile_x_t start_x = 5'd1,
    parameter game_pkg::tile_y_t start_y = 4'd1
) (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 step,
    input  game_pkg::key_code_t  key,
    input  game_pkg::tile_x_t    ghost_x,
    input  game_pkg::tile_y_t    ghost_y,
    output logic                 tile_wr,
    output game_pkg::tile_addr_t tile_addr,
    output game_pkg::tile_code_t tile_code,
    output game_pkg::score_t     score,
    output logic                 game_over,
    output game_pkg::tile_x_t    player_x,
    output game_pkg::tile_y_t    player_y
);

    logic               move_valid;
    game_pkg::heading_t heading;
    logic               pos_valid;
    logic               eat_valid;
    game_pkg::tile_x_t  eat_x;
    game_pkg::tile_y_t  eat_y;
    logic               hit_valid;
    game_pkg::tile_x_t  hit_x;
    game_pkg::tile_y_t  hit_y;

    heading_stage heading_stage0 (
        .clock      (clock),
        .resetn     (resetn),
        .step       (step),
        .key        (key),
        .game_over  (game_over), // Feedback from the collision stage
        .move_valid (move_valid),
        .heading    (heading)
    );

    // Mover position is the player position shown outside
    player_mover #(
        .start_x (start_x),
        .start_y (start_y)
    ) player_mover0 (
        .clock      (clock),
        .resetn     (resetn),
        .move_valid (move_valid),
        .heading    (heading),
        .pos_valid  (pos_valid),
        .pos_x      (player_x),
        .pos_y      (player_y)
    );

    food_eater #(
        .start_x (start_x),
        .start_y (start_y)
    ) food_eater0 (
        .clock     (clock),
        .resetn    (resetn),
        .pos_valid (pos_valid),
        .pos_x     (player_x),
        .pos_y     (player_y),
        .eat_valid (eat_valid),
        .eat_x     (eat_x),
        .eat_y     (eat_y),
        .score     (score)
    );

    ghost_check ghost_check0 (
        .clock     (clock),
        .resetn    (resetn),
        .eat_valid (eat_valid),
        .eat_x     (eat_x),
        .eat_y     (eat_y),
        .ghost_x   (ghost_x),
        .ghost_y   (ghost_y),
        .hit_valid (hit_valid),
        .hit_x     (hit_x),
        .hit_y     (hit_y),
        .game_over (game_over)
    );

    tile_painter #(
        .start_x (start_x),
        .start_y (start_y)
    ) tile_painter0 (
        .clock     (clock),
        .resetn    (resetn),
        .hit_valid (hit_valid),
        .hit_x     (hit_x),
        .hit_y     (hit_y),
        .tile_wr   (tile_wr),
        .tile_addr (tile_addr),
        .tile_code (tile_code)
    );

endmodule

`default_nettype wire

//--- verilog/player_mover.sv
`timescale 1ns/1ns
`default_nettype none

module player_mover #(
    parameter game_pkg::tile_x_t start_x = 5'd1,
    parameter game_pkg::tile_y_t start_y = 4'd1
) (
    input  logic               clock,
    input  logic               resetn,
    input  logic               move_valid,
    input  game_pkg::heading_t heading,
    output logic               pos_valid,
    output game_pkg::tile_x_t  pos_x,
    output game_pkg::tile_y_t  pos_y
);

    game_pkg::tile_x_t next_x;
    game_pkg::tile_y_t next_y;
    logic blocked;

    // Neighbor tile in the heading's direction
    always_comb begin
        next_x = pos_x;
        next_y = pos_y;
        case (heading)
            game_pkg::HEAD_UP:    next_y = pos_y - 1'b1;
            game_pkg::HEAD_DOWN:  next_y = pos_y + 1'b1;
            game_pkg::HEAD_LEFT:  next_x = pos_x - 1'b1;
            game_pkg::HEAD_RIGHT: next_x = pos_x + 1'b1;
            default: begin
                next_x = pos_x;
                next_y = pos_y;
            end
        endcase
    end

    // The border is a wall, so the neighbor never wraps around the grid
    assign blocked = (heading == game_pkg::HEAD_NONE) || game_pkg::is_wall(next_x, next_y);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            pos_valid <= 1'b0;
            pos_x     <= start_x;
            pos_y     <= start_y;
        end else begin
            pos_valid <= move_valid; // Blocked moves are still reported
            if (move_valid && !blocked) begin
                pos_x <= next_x;
                pos_y <= next_y;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/tile_painter.sv
`timescale 1ns/1ns
`default_nettype none

module tile_painter #(
    parameter game_pkg::tile_x_t start_x = 5'd1,
    parameter game_pkg::tile_y_t start_y = 4'd1
) (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 hit_valid,
    input  game_pkg::tile_x_t    hit_x,
    input  game_pkg::tile_y_t    hit_y,
    output logic                 tile_wr,
    output game_pkg::tile_addr_t tile_addr,
    output game_pkg::tile_code_t tile_code
);

    typedef enum logic {
        PAINT_ERASE, // Idle, erase goes out when a position arrives
        PAINT_DRAW
    } paint_state_t;

    paint_state_t state;
    game_pkg::tile_x_t last_x; // Tile the player was last drawn on
    game_pkg::tile_y_t last_y;
    game_pkg::tile_x_t new_x;
    game_pkg::tile_y_t new_y;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state   <= PAINT_ERASE;
            tile_wr <= 1'b0;
            last_x  <= start_x;
            last_y  <= start_y;
        end else begin
            tile_wr <= 1'b0;
            case (state)
                PAINT_ERASE: begin
                    if (hit_valid) begin
                        tile_wr <= 1'b1;
                        state   <= PAINT_DRAW;
                    end
                end
                PAINT_DRAW: begin
                    tile_wr <= 1'b1;
                    last_x  <= new_x;
                    last_y  <= new_y;
                    state   <= PAINT_ERASE;
                end
                default: state <= PAINT_ERASE;
            endcase
        end
    end

    // Write address and code only matter while tile_wr is high
    always_ff @(posedge clock) begin
        if (state == PAINT_ERASE && hit_valid) begin
            new_x     <= hit_x;
            new_y     <= hit_y;
            tile_addr <= game_pkg::tile_addr_of(last_x, last_y);
            tile_code <= game_pkg::TILE_EMPTY;
        end else if (state == PAINT_DRAW) begin
            tile_addr <= game_pkg::tile_addr_of(new_x, new_y);
            tile_code <= game_pkg::TILE_PLAYER;
        end
    end

endmodule

`default_nettype wire
